// ==== common/ddcPkg.sv ====
/*
  Shared types and address map of the DDC. Register addresses are 13-bit byte
  addresses, and each I or Q component is a signed 16-bit word.
*/
package ddcPkg;

    localparam int AddrWidth = 13;

    localparam logic [AddrWidth-1:0] DdcCenterFreqAddr = 13'h000;
    localparam logic [AddrWidth-1:0] DdcControlAddr    = 13'h004;
    localparam logic [AddrWidth-1:0] DdcDecimationAddr = 13'h008;

    localparam int SampleWidth = 16;

    typedef struct packed {
        logic signed [SampleWidth-1:0] i;
        logic signed [SampleWidth-1:0] q;
    } iqSample;

    typedef struct packed {
        logic [27:0] reserved;             // Reads as zero.
        logic        enableBasebandInputs; // Selects bbSample over the mixer.
        logic        bypassFir;
        logic        bypassHb;
        logic        bypassCic;
    } ddcControl;

    // The same bus word seen as raw bits or as control fields.
    typedef union packed {
        logic [31:0] raw;
        ddcControl   ctrl;
    } regWord;

    typedef struct packed {
        logic signed [31:0] centerFreq;    // Phase increment per input sample.
        logic               enableBasebandInputs;
        logic               bypassFir;
        logic               bypassHb;
        logic               bypassCic;
        logic [7:0]         decimation;    // Values 0 and 1 both mean rate 1.
    } ddcConfig;

endpackage

// ==== source/ddcRegs.sv ====
/*
  Register file on a plain chip-select bus with one write strobe per byte lane.
  Control and decimation registers only take byte 0. Reads are combinational.
*/
module ddcRegs (
    input  logic                          busClk,
    input  logic                          arstN,
    input  logic                          cs,
    input  logic [3:0]                    wr,
    input  logic [ddcPkg::AddrWidth-1:0]  addr,
    input  logic [31:0]                   dataIn,
    output logic [31:0]                   dataOut,
    output ddcPkg::ddcConfig              cfg,
    output logic                          cfgWrite
);
    import ddcPkg::*;

    regWord writeWord;
    regWord readWord;

    assign writeWord.raw = dataIn;

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            cfg      <= '0;
            cfgWrite <= 1'b0;
        end else begin
            cfgWrite <= 1'b0;
            if (cs) begin
                case (addr)
                    DdcCenterFreqAddr: begin
                        for (int k = 0; k < 4; k++) begin
                            if (wr[k]) begin
                                cfg.centerFreq[8*k +: 8] <= dataIn[8*k +: 8];
                            end
                        end
                    end
                    DdcControlAddr: begin
                        if (wr[0]) begin
                            cfg.enableBasebandInputs <= writeWord.ctrl.enableBasebandInputs;
                            cfg.bypassFir            <= writeWord.ctrl.bypassFir;
                            cfg.bypassHb             <= writeWord.ctrl.bypassHb;
                            cfg.bypassCic            <= writeWord.ctrl.bypassCic;
                            cfgWrite                 <= 1'b1; // Restarts the decimators.
                        end
                    end
                    DdcDecimationAddr: begin
                        if (wr[0]) begin
                            cfg.decimation <= dataIn[7:0];
                            cfgWrite       <= 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Readback mux. Unmapped addresses and a deselected bus return zero.
    always_comb begin
        readWord.raw = '0;
        if (cs) begin
            case (addr)
                DdcCenterFreqAddr: begin
                    readWord.raw = cfg.centerFreq;
                end
                DdcControlAddr: begin
                    readWord.ctrl.enableBasebandInputs = cfg.enableBasebandInputs;
                    readWord.ctrl.bypassFir            = cfg.bypassFir;
                    readWord.ctrl.bypassHb             = cfg.bypassHb;
                    readWord.ctrl.bypassCic            = cfg.bypassCic;
                end
                DdcDecimationAddr: begin
                    readWord.raw = {24'h0, cfg.decimation};
                end
                default: begin
                    readWord.raw = '0;
                end
            endcase
        end
    end

    assign dataOut = readWord.raw;

endmodule

// ==== mixer/ddcMixer.sv ====
/*
  NCO and real-to-complex mixer with a 64-entry sine table of amplitude 32767.
  The phase accumulator advances only on valid samples. Output is registered.
*/
module ddcMixer (
    input  logic                                  busClk,
    input  logic                                  arstN,
    input  logic signed [ddcPkg::SampleWidth-1:0] adcSample,
    input  ddcPkg::iqSample                       bbSample,
    input  logic                                  sampleValid,
    input  logic signed [31:0]                    centerFreq,
    input  logic                                  useBaseband,
    output ddcPkg::iqSample                       mixOut,
    output logic                                  mixValid
);
    import ddcPkg::*;

    localparam int  TableBits  = 6;
    localparam int  TableDepth = 1 << TableBits;
    localparam real Amplitude  = 32767.0;
    localparam int  ProdShift  = SampleWidth - 1;

    // One full sine period with each entry rounded to the nearest integer.
    function automatic logic [TableDepth*SampleWidth-1:0] buildSine();
        logic [TableDepth*SampleWidth-1:0] words;
        real                               angle;
        real                               scaled;
        int                                rounded;
        words = '0;
        for (int n = 0; n < TableDepth; n++) begin
            angle   = 6.283185307179586 * n / TableDepth;
            scaled  = Amplitude * $sin(angle);
            rounded = (scaled >= 0.0) ? $rtoi(scaled + 0.5) : $rtoi(scaled - 0.5);
            words[n*SampleWidth +: SampleWidth] = rounded[SampleWidth-1:0];
        end
        return words;
    endfunction

    localparam logic [TableDepth*SampleWidth-1:0] SineWords = buildSine();

    logic [31:0]                   phase;
    logic [TableBits-1:0]          sinIndex;
    logic [TableBits-1:0]          cosIndex;
    logic signed [SampleWidth-1:0] sinValue;
    logic signed [SampleWidth-1:0] cosValue;
    logic signed [31:0]            prodI;
    logic signed [31:0]            prodQ;

    assign sinIndex = phase[31 -: TableBits];
    assign cosIndex = sinIndex + TableBits'(TableDepth / 4); // Quarter period ahead.

    assign sinValue = SineWords[sinIndex*SampleWidth +: SampleWidth];
    assign cosValue = SineWords[cosIndex*SampleWidth +: SampleWidth];

    assign prodI = adcSample * cosValue;
    assign prodQ = -(adcSample * sinValue);

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            phase    <= '0;
            mixValid <= 1'b0;
        end else begin
            mixValid <= sampleValid;
            if (sampleValid) begin
                phase <= phase + unsigned'(centerFreq);
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (sampleValid) begin
            if (useBaseband) begin
                mixOut <= bbSample;
            end else begin
                mixOut.i <= SampleWidth'(prodI >>> ProdShift);
                mixOut.q <= SampleWidth'(prodQ >>> ProdShift);
            end
        end
    end

endmodule

// ==== cic/cicDecimator.sv ====
/*
  CIC decimator with rates 1 to 255 at full register growth and no gain correction.
  The output saturates to 16 bits. restart clears the rate counter and all CIC state.
*/
module cicDecimator #(
    parameter int Stages = 3
) (
    input  logic            busClk,
    input  logic            arstN,
    input  ddcPkg::iqSample inSample,
    input  logic            inValid,
    input  logic [7:0]      decimation,
    input  logic            bypass,
    input  logic            restart,
    output ddcPkg::iqSample outSample,
    output logic            outValid
);
    import ddcPkg::*;

    localparam int RateBits    = 8;
    localparam int GrowthWidth = SampleWidth + Stages * RateBits;

    localparam logic signed [GrowthWidth-1:0] SatMax = 2 ** (SampleWidth - 1) - 1;
    localparam logic signed [GrowthWidth-1:0] SatMin = -(2 ** (SampleWidth - 1));

    logic [RateBits-1:0]           rateCount;
    logic [RateBits-1:0]           lastCount;
    logic                          decimTick;
    logic signed [GrowthWidth-1:0] inWide [2];
    logic signed [GrowthWidth-1:0] integ [2][Stages];
    logic signed [GrowthWidth-1:0] integNext [2][Stages];
    logic signed [GrowthWidth-1:0] combDelay [2][Stages];
    logic signed [GrowthWidth-1:0] combNext [2][Stages];
    logic signed [SampleWidth-1:0] satOut [2];

    assign lastCount = (decimation == '0) ? '0 : decimation - 1'b1;
    assign decimTick = inValid && !bypass && (rateCount == lastCount);

    assign inWide[0] = inSample.i; // Sign extended.
    assign inWide[1] = inSample.q;

    // Integrators see the current input so the comb result is ready this cycle.
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            integNext[c][0] = integ[c][0] + inWide[c];
            for (int s = 1; s < Stages; s++) begin
                integNext[c][s] = integ[c][s] + integNext[c][s-1];
            end
            combNext[c][0] = integNext[c][Stages-1] - combDelay[c][0];
            for (int s = 1; s < Stages; s++) begin
                combNext[c][s] = combNext[c][s-1] - combDelay[c][s];
            end
            if (combNext[c][Stages-1] > SatMax) begin
                satOut[c] = SatMax[SampleWidth-1:0];
            end else if (combNext[c][Stages-1] < SatMin) begin
                satOut[c] = SatMin[SampleWidth-1:0];
            end else begin
                satOut[c] = combNext[c][Stages-1][SampleWidth-1:0];
            end
        end
    end

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            rateCount <= '0;
            outValid  <= 1'b0;
            integ     <= '{default: '0};
            combDelay <= '{default: '0};
        end else begin
            outValid <= bypass ? inValid : decimTick;
            if (restart) begin
                rateCount <= '0;
                integ     <= '{default: '0};
                combDelay <= '{default: '0};
            end else if (inValid && !bypass) begin
                rateCount <= decimTick ? '0 : rateCount + 1'b1;
                integ     <= integNext;
                if (decimTick) begin
                    for (int c = 0; c < 2; c++) begin
                        combDelay[c][0] <= integNext[c][Stages-1];
                        for (int s = 1; s < Stages; s++) begin
                            combDelay[c][s] <= combNext[c][s-1];
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (bypass && inValid) begin
            outSample <= inSample;
        end else if (decimTick) begin
            outSample.i <= satOut[0];
            outSample.q <= satOut[1];
        end
    end

endmodule

// ==== fir/firDecimator.sv ====
/*
  Symmetric FIR with an odd tap count and optional decimation by 2.
  Coefficients must sum to 2**CoefShift. Results are truncated to 16 bits.
*/
module firDecimator #(
    parameter int                      Taps      = 5,
    parameter logic [Taps-1:0][15:0]   Coeffs    = {16'sd1, 16'sd4, 16'sd6, 16'sd4, 16'sd1},
    parameter int                      CoefShift = 4,
    parameter int                      Decimate  = 1
) (
    input  logic            busClk,
    input  logic            arstN,
    input  ddcPkg::iqSample inSample,
    input  logic            inValid,
    input  logic            bypass,
    input  logic            restart,
    output ddcPkg::iqSample outSample,
    output logic            outValid
);
    import ddcPkg::*;

    localparam int AccWidth = 2 * SampleWidth + 8;
    localparam int Center   = Taps / 2;

    iqSample                       delayLine [Taps-1];
    logic signed [SampleWidth-1:0] tapValue [2][Taps];
    logic signed [AccWidth-1:0]    acc [2];
    logic                          decimPhase;
    logic                          emit;

    assign emit = inValid && !bypass && ((Decimate == 1) || decimPhase);

    // Tap 0 is the incoming sample so the result is ready in the same cycle.
    always_comb begin
        tapValue[0][0] = inSample.i;
        tapValue[1][0] = inSample.q;
        for (int k = 1; k < Taps; k++) begin
            tapValue[0][k] = delayLine[k-1].i;
            tapValue[1][k] = delayLine[k-1].q;
        end
        for (int c = 0; c < 2; c++) begin
            acc[c] = tapValue[c][Center] * signed'(Coeffs[Center]);
            for (int k = 0; k < Center; k++) begin
                acc[c] += (tapValue[c][k] + tapValue[c][Taps-1-k]) * signed'(Coeffs[k]);
            end
        end
    end

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            decimPhase <= 1'b0;
            outValid   <= 1'b0;
            delayLine  <= '{default: '0};
        end else begin
            outValid <= bypass ? inValid : emit;
            if (restart) begin
                decimPhase <= 1'b0;
                delayLine  <= '{default: '0};
            end else if (inValid && !bypass) begin
                decimPhase   <= (Decimate == 2) ? !decimPhase : 1'b0;
                delayLine[0] <= inSample;
                for (int k = 1; k < Taps - 1; k++) begin
                    delayLine[k] <= delayLine[k-1];
                end
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (bypass && inValid) begin
            outSample <= inSample;
        end else if (emit) begin
            outSample.i <= SampleWidth'(acc[0] >>> CoefShift); // Unity DC gain.
            outSample.q <= SampleWidth'(acc[1] >>> CoefShift);
        end
    end

endmodule

// ==== source/ddcTop.sv ====
/*
  DDC top level. Latency from sampleValid to outValid is 4 cycles in every mode.
  There is no back-pressure, so sampleValid pulses must be at least 2 cycles apart.
*/
module ddcTop #(
    parameter int                       CicStages = 3,
    parameter int                       HbTaps    = 7,
    parameter logic [HbTaps-1:0][15:0]  HbCoeffs  = {-16'sd1, 16'sd0, 16'sd9, 16'sd16,
                                                     16'sd9, 16'sd0, -16'sd1},
    parameter int                       HbShift   = 5,
    parameter int                       FirTaps   = 5,
    parameter logic [FirTaps-1:0][15:0] FirCoeffs = {16'sd1, 16'sd4, 16'sd6, 16'sd4, 16'sd1},
    parameter int                       FirShift  = 4
) (
    input  logic                                  busClk,
    input  logic                                  arstN,
    input  logic                                  cs,
    input  logic [3:0]                            wr,
    input  logic [ddcPkg::AddrWidth-1:0]          addr,
    input  logic [31:0]                           dataIn,
    output logic [31:0]                           dataOut,
    input  logic signed [ddcPkg::SampleWidth-1:0] adcSample,
    input  ddcPkg::iqSample                       bbSample,
    input  logic                                  sampleValid,
    output ddcPkg::iqSample                       sampleOut,
    output logic                                  outValid
);
    import ddcPkg::*;

    ddcConfig cfg;
    logic     cfgWrite;
    iqSample  mixOut;
    logic     mixValid;
    iqSample  cicOut;
    logic     cicValid;
    iqSample  hbOut;
    logic     hbValid;

    ddcRegs regs (
        .busClk   (busClk),
        .arstN    (arstN),
        .cs       (cs),
        .wr       (wr),
        .addr     (addr),
        .dataIn   (dataIn),
        .dataOut  (dataOut),
        .cfg      (cfg),
        .cfgWrite (cfgWrite)
    );

    ddcMixer mixer (
        .busClk      (busClk),
        .arstN       (arstN),
        .adcSample   (adcSample),
        .bbSample    (bbSample),
        .sampleValid (sampleValid),
        .centerFreq  (cfg.centerFreq),
        .useBaseband (cfg.enableBasebandInputs),
        .mixOut      (mixOut),
        .mixValid    (mixValid)
    );

    cicDecimator #(.Stages(CicStages)) cic (
        .busClk     (busClk),
        .arstN      (arstN),
        .inSample   (mixOut),
        .inValid    (mixValid),
        .decimation (cfg.decimation),
        .bypass     (cfg.bypassCic),
        .restart    (cfgWrite),
        .outSample  (cicOut),
        .outValid   (cicValid)
    );

    firDecimator #(
        .Taps      (HbTaps),
        .Coeffs    (HbCoeffs),
        .CoefShift (HbShift),
        .Decimate  (2)
    ) halfbandFilter (
        .busClk    (busClk),
        .arstN     (arstN),
        .inSample  (cicOut),
        .inValid   (cicValid),
        .bypass    (cfg.bypassHb),
        .restart   (cfgWrite),
        .outSample (hbOut),
        .outValid  (hbValid)
    );

    firDecimator #(
        .Taps      (FirTaps),
        .Coeffs    (FirCoeffs),
        .CoefShift (FirShift),
        .Decimate  (1)
    ) channelFilter (
        .busClk    (busClk),
        .arstN     (arstN),
        .inSample  (hbOut),
        .inValid   (hbValid),
        .bypass    (cfg.bypassFir),
        .restart   (cfgWrite),
        .outSample (sampleOut),
        .outValid  (outValid)
    );

endmodule

// ==== tests/ddcTb.sv ====
/*
  Self-checking testbench for ddcTop. Reads tests/ddcCases.txt from the project root.
  Bursts must space sampleValid pulses at least 2 cycles apart.
*/
module ddcTb;
    timeunit 1ns;
    timeprecision 10ps;

    import ddcPkg::*;

    localparam int Latency      = 4;     // sampleValid to outValid.
    localparam int DrainTimeout = 50;
    localparam int HistDepth    = 1024;

    logic                          busClk;
    logic                          arstN;
    logic                          cs;
    logic [3:0]                    wr;
    logic [AddrWidth-1:0]          addr;
    logic [31:0]                   dataIn;
    logic [31:0]                   dataOut;
    logic signed [SampleWidth-1:0] adcSample;
    iqSample                       bbSample;
    logic                          sampleValid;
    iqSample                       sampleOut;
    logic                          outValid;

    logic [31:0] lcgState;
    logic [31:0] regModel [3];             // Expected register contents.
    int          errorCount;
    int          testStartErrors;
    int          testIndex;
    int          okTests;
    int          badTests;
    string       testName;
    int          burstMode;
    int          skipCount;
    int          seenCount;
    int          burstCycle;
    iqSample     expSample;
    logic        sentValid [HistDepth];
    iqSample     sentValue [HistDepth];

    ddcTop DUT (
        .busClk      (busClk),
        .arstN       (arstN),
        .cs          (cs),
        .wr          (wr),
        .addr        (addr),
        .dataIn      (dataIn),
        .dataOut     (dataOut),
        .adcSample   (adcSample),
        .bbSample    (bbSample),
        .sampleValid (sampleValid),
        .sampleOut   (sampleOut),
        .outValid    (outValid)
    );

    initial begin
        busClk = 1'b0;
        forever #10 busClk = ~busClk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s expected %h got %h", name, exp, got);
            errorCount++;
        end
    endtask

    task automatic checkSample(input iqSample got, input iqSample exp);
        if (got !== exp) begin
            $display("ERROR sampleOut expected %h got %h", exp, got);
            errorCount++;
        end
    endtask

    task automatic checkCount(input int got, input int exp);
        if (got != exp) begin
            $display("ERROR outValid count expected %h got %h", exp, got);
            errorCount++;
        end
    endtask

    task automatic reportMalformedLine(input string text);
        $display("Case file line has too few fields: %s", text);
        errorCount++;
    endtask

    // Byte lanes apply to the center frequency and only byte 0 to the others.
    function automatic void applyWrite(input logic csVal, input logic [AddrWidth-1:0] a,
                                       input logic [3:0] lanes, input logic [31:0] d);
        if (csVal) begin
            if (a == DdcCenterFreqAddr) begin
                for (int k = 0; k < 4; k++) begin
                    if (lanes[k]) begin
                        regModel[0][8*k +: 8] = d[8*k +: 8];
                    end
                end
            end else if (a == DdcControlAddr && lanes[0]) begin
                regModel[1] = {28'h0, d[3:0]};             // Reserved bits read zero.
            end else if (a == DdcDecimationAddr && lanes[0]) begin
                regModel[2] = {24'h0, d[7:0]};
            end
        end
    endfunction

    task automatic busWrite(input logic csVal, input logic [AddrWidth-1:0] a,
                            input logic [3:0] lanes, input logic [31:0] d);
        @(posedge busClk);
        #2;
        cs     = csVal;
        wr     = lanes;
        addr   = a;
        dataIn = d;
        @(posedge busClk);
        #2;
        cs = 1'b0;
        wr = 4'h0;
        applyWrite(csVal, a, lanes, d);
    endtask

    task automatic busRead(input logic csVal, input logic [AddrWidth-1:0] a,
                           input logic [31:0] exp);
        @(posedge busClk);
        #2;
        cs   = csVal;
        wr   = 4'h0;
        addr = a;
        @(negedge busClk);
        checkWord("dataOut", dataOut, exp);        // Combinational readback.
        @(posedge busClk);
        #2;
        cs = 1'b0;
    endtask

    task automatic randomWrites(input int count);
        logic [AddrWidth-1:0] addrMap [3];
        int                   sel;
        logic [3:0]           lanes;
        logic [31:0]          data;
        addrMap = '{DdcCenterFreqAddr, DdcControlAddr, DdcDecimationAddr};
        for (int n = 0; n < count; n++) begin
            sel   = int'((nextRandom() >> 16) % 3);
            lanes = 4'(nextRandom() >> 28);
            data  = nextRandom();
            busWrite(1'b1, addrMap[sel], lanes, data);
            for (int j = 0; j < 3; j++) begin
                busRead(1'b1, addrMap[j], regModel[j]);
            end
        end
    endtask

    // Drives one clock of the sample port and samples the output mid-cycle.
    task automatic stepCycle(input logic valid, input iqSample bb,
                             input logic signed [SampleWidth-1:0] adc);
        @(posedge busClk);
        #2;
        sampleValid = valid;
        bbSample    = bb;
        adcSample   = adc;
        sentValid[burstCycle % HistDepth] = valid;
        sentValue[burstCycle % HistDepth] = bb;
        @(negedge busClk);
        if (outValid) begin
            seenCount++;
            if (burstCycle < Latency || !sentValid[(burstCycle - Latency) % HistDepth]) begin
                $display("Output at cycle %0d has no input sample 4 cycles before it",
                         burstCycle);
                errorCount++;
            end else if (burstMode == 2) begin
                checkSample(sampleOut, sentValue[(burstCycle - Latency) % HistDepth]);
            end else if (seenCount > skipCount) begin
                checkSample(sampleOut, expSample);
            end
        end
        burstCycle++;
    endtask

    task automatic runBurst(input int mode, input int x, input int y, input int count,
                            input int spacing, input int expCount, input int skip,
                            input int ei, input int eq);
        iqSample                       value;
        logic signed [SampleWidth-1:0] adcVal;
        int                            waited;
        burstMode   = mode;
        skipCount   = skip;
        seenCount   = 0;
        burstCycle  = 0;
        expSample.i = 16'(ei);
        expSample.q = 16'(eq);
        value.i     = (mode == 0) ? 16'(x) : 16'h0;
        value.q     = (mode == 0) ? 16'(y) : 16'h0;
        adcVal      = (mode == 1) ? 16'(x) : 16'h0;
        for (int k = 0; k < HistDepth; k++) begin
            sentValid[k] = 1'b0;
        end
        for (int n = 0; n < count; n++) begin
            if (mode == 2) begin
                value = nextRandom();
            end
            stepCycle(1'b1, value, adcVal);
            repeat (spacing - 1) stepCycle(1'b0, value, adcVal);
        end
        waited = 0;
        while (seenCount < expCount && waited < DrainTimeout) begin
            stepCycle(1'b0, value, adcVal);
            waited++;
        end
        if (seenCount < expCount) begin
            $display("Timeout waiting for outValid, %0d of %0d outputs arrived",
                     seenCount, expCount);
            errorCount++;
        end
        repeat (Latency) stepCycle(1'b0, value, adcVal); // Catches surplus outputs.
        checkCount(seenCount, expCount);
    endtask

    task automatic finishTest();
        if (testIndex > 0) begin
            if (errorCount == testStartErrors) begin
                $display("test %0d %s: ok", testIndex, testName);
                okTests++;
            end else begin
                $display("test %0d %s: %0d errors", testIndex, testName,
                         errorCount - testStartErrors);
                badTests++;
            end
        end
    endtask

    initial begin
        int          fd;
        int          code;
        string       line;
        byte         op;
        int          csVal;
        logic [31:0] addrVal;
        logic [31:0] lanesVal;
        logic [31:0] dataVal;
        int          mode;
        int          x;
        int          y;
        int          count;
        int          spacing;
        int          expCount;
        int          skip;
        int          ei;
        int          eq;
        arstN       = 1'b0;
        cs          = 1'b0;
        wr          = 4'h0;
        addr        = '0;
        dataIn      = '0;
        adcSample   = '0;
        bbSample    = '0;
        sampleValid = 1'b0;
        lcgState    = 32'd9966;
        regModel    = '{default: '0};
        errorCount  = 0;
        testIndex   = 0;
        okTests     = 0;
        badTests    = 0;
        repeat (10) @(posedge busClk);
        #2;
        arstN = 1'b1;
        fd = $fopen("tests/ddcCases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file tests/ddcCases.txt");
            errorCount++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                while (line.len() > 0 && (line.getc(line.len() - 1) == "\n" ||
                                          line.getc(line.len() - 1) == "\r")) begin
                    line = line.substr(0, line.len() - 2);
                end
                if (code != 0 && line.len() > 0 && line.getc(0) != "#") begin
                    op   = line.getc(0);
                    line = line.substr(2, line.len() - 1);
                    if (op == "T") begin
                        finishTest();
                        testIndex++;
                        testName        = line;
                        testStartErrors = errorCount;
                    end else if (op == "W") begin
                        code = $sscanf(line, "%d %h %h %h", csVal, addrVal, lanesVal, dataVal);
                        if (code == 4) begin
                            busWrite(csVal[0], addrVal[AddrWidth-1:0], lanesVal[3:0],
                                     dataVal);
                        end else begin
                            reportMalformedLine(line);
                        end
                    end else if (op == "R") begin
                        code = $sscanf(line, "%d %h %h", csVal, addrVal, dataVal);
                        if (code == 3) begin
                            busRead(csVal[0], addrVal[AddrWidth-1:0], dataVal);
                        end else begin
                            reportMalformedLine(line);
                        end
                    end else if (op == "L") begin
                        code = $sscanf(line, "%d", count);
                        if (code == 1) begin
                            randomWrites(count);
                        end else begin
                            reportMalformedLine(line);
                        end
                    end else if (op == "B") begin
                        code = $sscanf(line, "%d %d %d %d %d %d %d %d %d", mode, x, y,
                                       count, spacing, expCount, skip, ei, eq);
                        if (code == 9) begin
                            runBurst(mode, x, y, count, spacing, expCount, skip, ei, eq);
                        end else begin
                            reportMalformedLine(line);
                        end
                    end else begin
                        $display("Unknown operation in case file line: %s", line);
                        errorCount++;
                    end
                end
            end
            $fclose(fd);
        end
        finishTest();
        $display("%0d tests ok, %0d tests with errors, %0d failed checks",
                 okTests, badTests, errorCount);
        if (errorCount == 0 && okTests > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tests/ddcCases.txt ====
# T name | W cs addr wr data | R cs addr expected | L randomWrites (bus fields in hex)
# B mode i q count spacing expCount skip expI expQ (decimal; mode 0 bb, 1 adc, 2 bb random)
T reset values and readback rules
R 1 000 00000000
R 1 004 00000000
R 1 008 00000000
W 1 004 F FFFFFFFF
R 1 004 0000000F
W 1 004 2 00000000
R 1 004 0000000F
W 1 008 F 12345678
R 1 008 00000078
W 1 000 F 89ABCDEF
R 1 000 89ABCDEF
R 0 000 00000000
R 0 004 00000000
R 0 008 00000000
R 1 00C 00000000
R 1 010 00000000
R 1 1FFC 00000000
W 1 00C F 55555555
R 1 00C 00000000
W 0 000 F 11111111
R 1 000 89ABCDEF
T byte-lane register writes
L 24
T full bypass
W 1 000 F 00000000
W 1 004 1 0000000F
B 2 0 0 8 2 8 0 0 0
B 2 0 0 6 3 6 0 0 0
T CIC rate and gain
W 1 004 1 0000000E
W 1 008 1 00000001
B 0 1234 -4321 8 2 8 3 1234 -4321
W 1 008 1 00000002
B 0 100 -7 16 2 8 3 800 -56
W 1 008 1 00000004
B 0 50 -20 24 3 6 3 3200 -1280
W 1 008 1 00000005
B 0 300 -300 30 2 6 3 32767 -32768
T halfband and channel FIR DC gain
W 1 004 1 00000009
B 0 1000 -2500 24 2 12 7 1000 -2500
W 1 004 1 0000000D
B 0 -1500 700 24 3 12 3 -1500 700
T mixer at zero frequency
W 1 000 F 00000000
W 1 004 1 00000007
B 1 1000 0 6 2 6 0 999 0
B 1 -1000 0 6 2 6 0 -1000 0
B 1 32767 0 6 3 6 0 32766 0
B 1 -32768 0 6 2 6 0 -32767 0

// ==== files.f ====
common/ddcPkg.sv
source/ddcRegs.sv
mixer/ddcMixer.sv
cic/cicDecimator.sv
fir/firDecimator.sv
source/ddcTop.sv
tests/ddcTb.sv
